// ==== Bender.yml ====
package:
  name: mips16_exe

sources:
  - mips16_isa_pkg.sv
  - mips16_pipe_pkg.sv
  - pipe_ctrl_if.sv
  - id_decode.sv
  - reg_file.sv
  - id_exe.sv
  - alu_exec.sv
  - mips16_exe_top.sv
  - target: test
    files:
      - tb_mips16_exe.sv

// ==== alu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec
	import mips16_isa_pkg::*, mips16_pipe_pkg::*;
(
	input  logic [WORD_W-1:0] op1,
	input  logic [WORD_W-1:0] op2,
	input  alu_op_e           alu_op,
	output logic [WORD_W-1:0] result
);

	logic [3:0] amount;

	// Shift field of zero encodes eight
	assign amount = (op2[2:0] == 3'b000) ? 4'd8 : {1'b0, op2[2:0]};

	always_comb begin
		case (alu_op)
			ALU_ADD:   result = op1 + op2;
			ALU_SUB:   result = op1 - op2;
			ALU_AND:   result = op1 & op2;
			ALU_OR:    result = op1 | op2;
			ALU_CMP:   result = (op1 == op2) ? WORD_W'(0) : WORD_W'(1); // T flag
			ALU_SLL:   result = op1 << amount;
			ALU_SRA:   result = $unsigned($signed(op1) >>> amount);
			ALU_SRL:   result = op1 >> amount;
			ALU_PASS1: result = op1;
			default:   result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== id_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_decode
	import mips16_isa_pkg::*, mips16_pipe_pkg::*;
(
	input  logic [WORD_W-1:0]     instr,
	input  logic [WORD_W-1:0]     pc,
	output logic [REG_ADDR_W-1:0] rd_addr1,
	output logic [REG_ADDR_W-1:0] rd_addr2,
	pipe_ctrl_if.dec              ctrl
);

	ctrl_t                 c;
	logic [REG_ADDR_W-1:0] rx;
	logic [REG_ADDR_W-1:0] ry;
	logic [REG_ADDR_W-1:0] rz;

	assign rx = {1'b0, instr[10:8]};
	assign ry = {1'b0, instr[7:5]};
	assign rz = {1'b0, instr[4:2]};

	always_comb begin
		c        = CTRL_NOP; // Branches, jumps and unknown words
		rd_addr1 = rx;
		rd_addr2 = ry;
		case (instr[15:11])
			OPC_ADDIU: c = '{1'b0, 1'b0, 1'b1, rx, ALU_ADD, OP1_REG1, IMM_SE8};
			OPC_ADDIU3: c = '{1'b0, 1'b0, 1'b1, ry, ALU_ADD, OP1_REG1, IMM_SE4};
			OPC_SPEC: begin
				if (instr[10:8] == FN_ADDSP) begin
					rd_addr1 = REG_SP;
					c = '{1'b0, 1'b0, 1'b1, REG_SP, ALU_ADD, OP1_REG1, IMM_SE8};
				end else if (instr[10:8] == FN_MTSP && instr[4:0] == 5'b00000) begin
					rd_addr1 = ry; // Source sits in [7:5]
					c = '{1'b0, 1'b0, 1'b1, REG_SP, ALU_PASS1, OP1_REG1, IMM_ZERO};
				end
			end
			OPC_RR: begin
				if (instr[1:0] == FN_ADDU)
					c = '{1'b0, 1'b0, 1'b1, rz, ALU_ADD, OP1_REG1, IMM_REG2};
				else if (instr[1:0] == FN_SUBU)
					c = '{1'b0, 1'b0, 1'b1, rz, ALU_SUB, OP1_REG1, IMM_REG2};
			end
			OPC_ALU: begin
				case (instr[4:0])
					FN_AND: c = '{1'b0, 1'b0, 1'b1, rx, ALU_AND, OP1_REG1, IMM_REG2};
					FN_OR:  c = '{1'b0, 1'b0, 1'b1, rx, ALU_OR, OP1_REG1, IMM_REG2};
					FN_CMP: c = '{1'b0, 1'b0, 1'b1, REG_T, ALU_CMP, OP1_REG1, IMM_REG2};
					FN_SRAV: begin
						rd_addr1 = ry; // ry >>= rx
						rd_addr2 = rx;
						c = '{1'b0, 1'b0, 1'b1, ry, ALU_SRA, OP1_REG1, IMM_REG2};
					end
					default: begin
						if (instr[7:0] == FN_MFPC)
							c = '{1'b0, 1'b0, 1'b1, rx, ALU_PASS1, OP1_PC1, IMM_ZERO};
					end
				endcase
			end
			OPC_LI: c = '{1'b0, 1'b0, 1'b1, rx, ALU_PASS1, OP1_IMM, IMM_ZERO};
			OPC_LW: c = '{1'b1, 1'b0, 1'b1, ry, ALU_ADD, OP1_REG1, IMM_SE5};
			OPC_LW_SP: begin
				rd_addr1 = REG_SP;
				c = '{1'b1, 1'b0, 1'b1, rx, ALU_ADD, OP1_REG1, IMM_SE8};
			end
			OPC_SW: c = '{1'b0, 1'b1, 1'b0, '0, ALU_ADD, OP1_REG1, IMM_SE5};
			OPC_SW_SP: begin
				rd_addr1 = REG_SP;
				rd_addr2 = rx; // Store data
				c = '{1'b0, 1'b1, 1'b0, '0, ALU_ADD, OP1_REG1, IMM_SE8};
			end
			OPC_IH: begin
				if (instr[7:0] == FN_MFIH) begin
					rd_addr1 = REG_IH;
					c = '{1'b0, 1'b0, 1'b1, rx, ALU_PASS1, OP1_REG1, IMM_ZERO};
				end else if (instr[7:0] == FN_MTIH) begin
					c = '{1'b0, 1'b0, 1'b1, REG_IH, ALU_PASS1, OP1_REG1, IMM_ZERO};
				end
			end
			OPC_SHIFT: begin
				case (instr[1:0])
					FN_SLL: c = '{1'b0, 1'b0, 1'b1, rx, ALU_SLL, OP1_REG2, IMM_SHAMT};
					FN_SRL: c = '{1'b0, 1'b0, 1'b1, rx, ALU_SRL, OP1_REG2, IMM_SHAMT};
					FN_SRA: c = '{1'b0, 1'b0, 1'b1, rx, ALU_SRA, OP1_REG2, IMM_SHAMT};
					default: c = CTRL_NOP;
				endcase
			end
			OPC_MOVE: begin
				if (instr[4:0] == 5'b00000)
					c = '{1'b0, 1'b0, 1'b1, rx, ALU_PASS1, OP1_REG2, IMM_ZERO};
			end
			OPC_NOP: c = CTRL_NOP; // Explicit bubble
			default: c = CTRL_NOP;
		endcase
	end

	assign ctrl.ctrl  = c;
	assign ctrl.instr = instr;
	assign ctrl.pc    = pc;

endmodule

`default_nettype wire

// ==== id_exe.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_exe
	import mips16_isa_pkg::*, mips16_pipe_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              hold,
	input  logic              flush,
	pipe_ctrl_if.stage        ctrl,
	output logic [WORD_W-1:0] op1,
	output logic [WORD_W-1:0] op2,
	output logic [WORD_W-1:0] mem_write_value,
	output logic [WORD_W-1:0] pc_out,
	output ctrl_t             ctrl_out,
	output logic [ACT_W-1:0]  mem_act
);

	logic [WORD_W-1:0] op1_next;
	logic [WORD_W-1:0] op2_next;
	logic [WORD_W-1:0] imm_se8;
	logic [WORD_W-1:0] imm_se5;
	logic [WORD_W-1:0] imm_se4;
	logic [WORD_W-1:0] imm_ze8;
	logic [WORD_W-1:0] shamt;

	//////////////////////////////////////////////////////////////////////
	// Immediate extension
	//////////////////////////////////////////////////////////////////////
	assign imm_se8 = {{(WORD_W-8){ctrl.instr[7]}}, ctrl.instr[7:0]}; // ADDIU, ADDSP, *_SP
	assign imm_se5 = {{(WORD_W-5){ctrl.instr[4]}}, ctrl.instr[4:0]}; // LW, SW
	assign imm_se4 = {{(WORD_W-4){ctrl.instr[3]}}, ctrl.instr[3:0]}; // ADDIU3
	assign imm_ze8 = {{(WORD_W-8){1'b0}}, ctrl.instr[7:0]};          // LI
	assign shamt   = {{(WORD_W-3){1'b0}}, ctrl.instr[4:2]};

	always_comb begin
		case (ctrl.ctrl.op1_sel)
			OP1_REG1: op1_next = ctrl.rd_data1;
			OP1_REG2: op1_next = ctrl.rd_data2;
			OP1_PC1:  op1_next = ctrl.pc + WORD_W'(1);
			default:  op1_next = imm_ze8;
		endcase
	end

	always_comb begin
		case (ctrl.ctrl.imm_sel)
			IMM_REG2:  op2_next = ctrl.rd_data2;
			IMM_SE8:   op2_next = imm_se8;
			IMM_SE4:   op2_next = imm_se4;
			IMM_SE5:   op2_next = imm_se5;
			IMM_ZE8:   op2_next = imm_ze8;
			IMM_SHAMT: op2_next = shamt;
			default:   op2_next = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Pipeline register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_out        <= CTRL_NOP;
			op1             <= '0;
			op2             <= '0;
			mem_write_value <= '0;
			pc_out          <= '0;
			mem_act         <= '0;
		end else if (!hold) begin // Hold keeps every field
			// Counts the instruction leaving the register
			if (ctrl_out.mem_read || ctrl_out.mem_write)
				mem_act <= mem_act + ACT_W'(1);
			pc_out <= ctrl.pc;
			if (flush) begin
				ctrl_out        <= CTRL_NOP; // Bubble
				op1             <= '0;
				op2             <= '0;
				mem_write_value <= '0;
			end else begin
				ctrl_out        <= ctrl.ctrl;
				op1             <= op1_next;
				op2             <= op2_next;
				mem_write_value <= ctrl.rd_data2; // Store data
			end
		end
	end

endmodule

`default_nettype wire

// ==== mips16_exe.f ====
mips16_isa_pkg.sv
mips16_pipe_pkg.sv
pipe_ctrl_if.sv
id_decode.sv
reg_file.sv
id_exe.sv
alu_exec.sv
mips16_exe_top.sv
tb_mips16_exe.sv

// ==== mips16_exe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips16_exe_top
	import mips16_isa_pkg::*, mips16_pipe_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [WORD_W-1:0]     instr,
	input  logic [WORD_W-1:0]     pc,
	input  logic                  hold,
	input  logic                  flush,
	output logic [WORD_W-1:0]     alu_result,
	output logic                  reg_write_out,
	output logic [REG_ADDR_W-1:0] reg_addr_out,
	output logic                  mem_read_out,
	output logic                  mem_write_out,
	output logic [WORD_W-1:0]     mem_write_value,
	output logic [WORD_W-1:0]     pc_out,
	output logic [ACT_W-1:0]      mem_act
);

	pipe_ctrl_if ctrl_bus ();

	logic [REG_ADDR_W-1:0] rd_addr1;
	logic [REG_ADDR_W-1:0] rd_addr2;
	logic [WORD_W-1:0]     op1;
	logic [WORD_W-1:0]     op2;
	logic                  wr_en;
	ctrl_t                 ctrl_out;

	id_decode u_decode (
		.instr    (instr),
		.pc       (pc),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.ctrl     (ctrl_bus.dec)
	);

	reg_file u_regs (
		.clk      (clk),
		.arst_n   (arst_n),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.rd_data1 (ctrl_bus.rd_data1),
		.rd_data2 (ctrl_bus.rd_data2),
		.wr_en    (wr_en),
		.wr_addr  (ctrl_out.reg_addr),
		.wr_data  (alu_result)
	);

	id_exe u_id_exe (
		.clk             (clk),
		.arst_n          (arst_n),
		.hold            (hold),
		.flush           (flush),
		.ctrl            (ctrl_bus.stage),
		.op1             (op1),
		.op2             (op2),
		.mem_write_value (mem_write_value),
		.pc_out          (pc_out),
		.ctrl_out        (ctrl_out),
		.mem_act         (mem_act)
	);

	alu_exec u_alu (
		.op1    (op1),
		.op2    (op2),
		.alu_op (ctrl_out.alu_op),
		.result (alu_result)
	);

	// Load data returns outside this slice, so a load's address is not written back
	assign wr_en = ctrl_out.reg_write & ~ctrl_out.mem_read;

	assign reg_write_out = ctrl_out.reg_write;
	assign reg_addr_out  = ctrl_out.reg_addr;
	assign mem_read_out  = ctrl_out.mem_read;
	assign mem_write_out = ctrl_out.mem_write;

endmodule

`default_nettype wire

// ==== mips16_isa_pkg.sv ====
`default_nettype none

package mips16_isa_pkg;

	localparam int WORD_W     = 16; // Data and instruction width
	localparam int REG_ADDR_W = 4;
	localparam int ACT_W      = 4;  // Memory access counter
	localparam int NUM_REGS   = 12;

	//////////////////////////////////////////////////////////////////////
	// Major opcodes, instr[15:11]
	//////////////////////////////////////////////////////////////////////
	localparam logic [4:0] OPC_ADDIU  = 5'b01001;
	localparam logic [4:0] OPC_ADDIU3 = 5'b01000;
	localparam logic [4:0] OPC_SPEC   = 5'b01100; // ADDSP, MTSP, BTEQZ, BTNEZ
	localparam logic [4:0] OPC_RR     = 5'b11100; // ADDU, SUBU
	localparam logic [4:0] OPC_ALU    = 5'b11101; // AND, OR, CMP, MFPC, SRAV, jumps
	localparam logic [4:0] OPC_LI     = 5'b01101;
	localparam logic [4:0] OPC_LW     = 5'b10011;
	localparam logic [4:0] OPC_LW_SP  = 5'b10010;
	localparam logic [4:0] OPC_SW     = 5'b11011;
	localparam logic [4:0] OPC_SW_SP  = 5'b11010;
	localparam logic [4:0] OPC_IH     = 5'b11110; // MFIH, MTIH
	localparam logic [4:0] OPC_SHIFT  = 5'b00110;
	localparam logic [4:0] OPC_MOVE   = 5'b01111;
	localparam logic [4:0] OPC_NOP    = 5'b00001;

	// Function fields
	localparam logic [2:0] FN_ADDSP = 3'b011; // instr[10:8]
	localparam logic [2:0] FN_MTSP  = 3'b100;
	localparam logic [1:0] FN_ADDU  = 2'b01;  // instr[1:0]
	localparam logic [1:0] FN_SUBU  = 2'b11;
	localparam logic [4:0] FN_AND   = 5'b01100; // instr[4:0]
	localparam logic [4:0] FN_OR    = 5'b01101;
	localparam logic [4:0] FN_CMP   = 5'b01010;
	localparam logic [4:0] FN_SRAV  = 5'b00111;
	localparam logic [7:0] FN_MFPC  = 8'b01000000; // instr[7:0]
	localparam logic [7:0] FN_MFIH  = 8'b00000000;
	localparam logic [7:0] FN_MTIH  = 8'b00000001;
	localparam logic [1:0] FN_SLL   = 2'b00;
	localparam logic [1:0] FN_SRL   = 2'b10;
	localparam logic [1:0] FN_SRA   = 2'b11;

	// Special registers above the eight general ones
	localparam logic [REG_ADDR_W-1:0] REG_SP = 4'd8;
	localparam logic [REG_ADDR_W-1:0] REG_IH = 4'd9;
	localparam logic [REG_ADDR_W-1:0] REG_T  = 4'd10;
	localparam logic [REG_ADDR_W-1:0] REG_RA = 4'd11;

endpackage

`default_nettype wire

// ==== mips16_pipe_pkg.sv ====
`default_nettype none

package mips16_pipe_pkg;

	import mips16_isa_pkg::*;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_CMP,
		ALU_SLL,
		ALU_SRA,
		ALU_SRL,
		ALU_PASS1
	} alu_op_e;

	typedef enum logic [2:0] {
		IMM_REG2,  // Read value 2
		IMM_SE8,
		IMM_SE4,
		IMM_SE5,
		IMM_ZE8,
		IMM_SHAMT, // instr[4:2]
		IMM_ZERO
	} imm_sel_e;

	typedef enum logic [1:0] {
		OP1_REG1,
		OP1_REG2,
		OP1_PC1,   // pc + 1
		OP1_IMM    // Zero extended imm8
	} op1_sel_e;

	typedef struct packed {
		logic                  mem_read;
		logic                  mem_write;
		logic                  reg_write;
		logic [REG_ADDR_W-1:0] reg_addr;
		alu_op_e               alu_op;
		op1_sel_e              op1_sel;
		imm_sel_e              imm_sel;
	} ctrl_t;

	// AND with a zero op2 gives a zero result for any bubble
	localparam ctrl_t CTRL_NOP = '{
		mem_read:  1'b0,
		mem_write: 1'b0,
		reg_write: 1'b0,
		reg_addr:  '0,
		alu_op:    ALU_AND,
		op1_sel:   OP1_IMM,
		imm_sel:   IMM_ZERO
	};

endpackage

`default_nettype wire

// ==== pipe_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pipe_ctrl_if
	import mips16_isa_pkg::*, mips16_pipe_pkg::*;
();

	ctrl_t             ctrl;     // Decoded control
	logic [WORD_W-1:0] instr;    // Raw word, immediates are cut in id_exe
	logic [WORD_W-1:0] pc;
	logic [WORD_W-1:0] rd_data1; // From the register file
	logic [WORD_W-1:0] rd_data2;

	modport dec (
		output ctrl, instr, pc
	);

	modport stage (
		input ctrl, instr, pc, rd_data1, rd_data2
	);

endinterface

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import mips16_isa_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [REG_ADDR_W-1:0] rd_addr1,
	input  logic [REG_ADDR_W-1:0] rd_addr2,
	output logic [WORD_W-1:0]     rd_data1,
	output logic [WORD_W-1:0]     rd_data2,
	input  logic                  wr_en,
	input  logic [REG_ADDR_W-1:0] wr_addr,
	input  logic [WORD_W-1:0]     wr_data
);

	logic [WORD_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr < NUM_REGS) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-through so a dependent instruction sees the new value
	always_comb begin
		if (wr_en && wr_addr == rd_addr1)
			rd_data1 = wr_data;
		else if (rd_addr1 < NUM_REGS)
			rd_data1 = regs[rd_addr1];
		else
			rd_data1 = '0; // Unmapped index
		if (wr_en && wr_addr == rd_addr2)
			rd_data2 = wr_data;
		else if (rd_addr2 < NUM_REGS)
			rd_data2 = regs[rd_addr2];
		else
			rd_data2 = '0;
	end

endmodule

`default_nettype wire

// ==== tb_mips16_exe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips16_exe
	import mips16_isa_pkg::*;
();

	typedef struct packed {
		int                    due;    // Negedge count at which it is sampled
		logic [WORD_W-1:0]     result;
		logic                  rw;
		logic [REG_ADDR_W-1:0] ra;
		logic                  mr;
		logic                  mw;
		logic [WORD_W-1:0]     wval;
		logic [WORD_W-1:0]     pcv;
		logic [ACT_W-1:0]      act;
	} exp_t;

	localparam logic [WORD_W-1:0] NOP_WORD = {OPC_NOP, 11'd0};

	logic                  clk;
	logic                  arst_n;
	logic [WORD_W-1:0]     instr;
	logic [WORD_W-1:0]     pc;
	logic                  hold;
	logic                  flush;
	logic [WORD_W-1:0]     alu_result;
	logic                  reg_write_out;
	logic [REG_ADDR_W-1:0] reg_addr_out;
	logic                  mem_read_out;
	logic                  mem_write_out;
	logic [WORD_W-1:0]     mem_write_value;
	logic [WORD_W-1:0]     pc_out;
	logic [ACT_W-1:0]      mem_act;

	logic [WORD_W-1:0] model_rf [NUM_REGS]; // Architectural state
	exp_t              cur;                 // Outputs of the latched instruction
	logic [ACT_W-1:0]  act_model;
	logic [WORD_W-1:0] pc_ctr;
	exp_t              exp_q [$];
	string             name_q [$];
	string             cur_test;
	int                neg_cnt = 0;
	int                chk_cnt = 0;
	int                err_cnt = 0;
	int                test_chk0;
	int                test_err0;

	mips16_exe_top DUT (
		.clk             (clk),
		.arst_n          (arst_n),
		.instr           (instr),
		.pc              (pc),
		.hold            (hold),
		.flush           (flush),
		.alu_result      (alu_result),
		.reg_write_out   (reg_write_out),
		.reg_addr_out    (reg_addr_out),
		.mem_read_out    (mem_read_out),
		.mem_write_out   (mem_write_out),
		.mem_write_value (mem_write_value),
		.pc_out          (pc_out),
		.mem_act         (mem_act)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction words and reference model
	//////////////////////////////////////////////////////////////////////
	function automatic logic [WORD_W-1:0] imm8_word(input logic [4:0] opc,
			input logic [2:0] rx, input logic [7:0] imm);
		return {opc, rx, imm};
	endfunction

	function automatic logic [WORD_W-1:0] rr_word(input logic [4:0] opc,
			input logic [2:0] rx, input logic [2:0] ry, input logic [4:0] low);
		return {opc, rx, ry, low};
	endfunction

	function automatic logic [2:0] any_reg();
		return 3'($urandom);
	endfunction

	function automatic logic [7:0] any_byte();
		return 8'($urandom);
	endfunction

	function automatic exp_t dest_write(input exp_t e, input logic [REG_ADDR_W-1:0] ra,
			input logic [WORD_W-1:0] v);
		exp_t r;
		r        = e;
		r.rw     = 1'b1;
		r.ra     = ra;
		r.result = v;
		return r;
	endfunction

	// Expected outputs of one instruction against the current model state
	function automatic exp_t predict(input logic [WORD_W-1:0] w, input logic [WORD_W-1:0] p);
		exp_t                  e;
		logic [WORD_W-1:0]     x;
		logic [WORD_W-1:0]     y;
		logic [WORD_W-1:0]     s8;
		logic [WORD_W-1:0]     s5;
		logic [3:0]            sa;
		logic [REG_ADDR_W-1:0] rx;
		e  = '0;
		rx = {1'b0, w[10:8]};
		x  = model_rf[w[10:8]];
		y  = model_rf[w[7:5]];
		s8 = {{8{w[7]}}, w[7:0]};
		s5 = {{11{w[4]}}, w[4:0]};
		sa = (w[4:2] == 3'd0) ? 4'd8 : {1'b0, w[4:2]}; // Zero field shifts by eight
		case (w[15:11])
			OPC_ADDIU:  e = dest_write(e, rx, x + s8);
			OPC_ADDIU3: e = dest_write(e, {1'b0, w[7:5]}, x + {{12{w[3]}}, w[3:0]});
			OPC_SPEC: begin
				if (w[10:8] == FN_ADDSP)
					e = dest_write(e, REG_SP, model_rf[REG_SP] + s8);
				else if (w[10:8] == FN_MTSP && w[4:0] == 5'd0)
					e = dest_write(e, REG_SP, y);
			end
			OPC_RR: begin
				if (w[1:0] == FN_ADDU)
					e = dest_write(e, {1'b0, w[4:2]}, x + y);
				else if (w[1:0] == FN_SUBU)
					e = dest_write(e, {1'b0, w[4:2]}, x - y);
			end
			OPC_ALU: begin
				if (w[4:0] == FN_AND)
					e = dest_write(e, rx, x & y);
				else if (w[4:0] == FN_OR)
					e = dest_write(e, rx, x | y);
				else if (w[4:0] == FN_CMP)
					e = dest_write(e, REG_T, (x == y) ? 16'd0 : 16'd1);
				else if (w[7:0] == FN_MFPC)
					e = dest_write(e, rx, p + 16'd1);
			end
			OPC_LI: e = dest_write(e, rx, {8'd0, w[7:0]});
			OPC_LW: begin
				e    = dest_write(e, {1'b0, w[7:5]}, x + s5);
				e.mr = 1'b1;
			end
			OPC_LW_SP: begin
				e    = dest_write(e, rx, model_rf[REG_SP] + s8);
				e.mr = 1'b1;
			end
			OPC_SW: begin
				e.mw     = 1'b1;
				e.result = x + s5;
				e.wval   = y; // Data register ry
			end
			OPC_SW_SP: begin
				e.mw     = 1'b1;
				e.result = model_rf[REG_SP] + s8;
				e.wval   = x;
			end
			OPC_IH: begin
				if (w[7:0] == FN_MFIH)
					e = dest_write(e, rx, model_rf[REG_IH]);
				else if (w[7:0] == FN_MTIH)
					e = dest_write(e, REG_IH, x);
			end
			OPC_SHIFT: begin
				if (w[1:0] == FN_SLL)
					e = dest_write(e, rx, y << sa);
				else if (w[1:0] == FN_SRL)
					e = dest_write(e, rx, y >> sa);
				else if (w[1:0] == FN_SRA)
					e = dest_write(e, rx, $unsigned($signed(y) >>> sa));
			end
			OPC_MOVE: begin
				if (w[4:0] == 5'd0)
					e = dest_write(e, rx, y);
			end
			default: e = '0;
		endcase
		return e;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checking
	//////////////////////////////////////////////////////////////////////
	task automatic check(input string name, input string field,
			input logic [WORD_W-1:0] exp_v, input logic [WORD_W-1:0] act_v);
		chk_cnt++;
		if (exp_v !== act_v) begin
			err_cnt++;
			$display("[ERROR] %s %s: expected %h, actual %h", name, field, exp_v, act_v);
		end
	endtask

	task automatic step(input string mnem, input logic [WORD_W-1:0] w,
			input logic h, input logic f);
		exp_t e;
		@(posedge clk);
		instr <= w;
		pc    <= pc_ctr;
		hold  <= h;
		flush <= f;
		if (!h) begin
			if (cur.mr || cur.mw)
				act_model = act_model + 1'b1; // Counts the instruction leaving
			if (f) begin
				cur = '0;
			end else begin
				cur = predict(w, pc_ctr);
				if (cur.rw && !cur.mr)
					model_rf[cur.ra] = cur.result; // Load data lands outside the slice
			end
			cur.pcv = pc_ctr;
			cur.act = act_model;
		end
		e     = cur;
		e.due = neg_cnt + 2;
		exp_q.push_back(e);
		name_q.push_back({cur_test, " ", mnem});
		pc_ctr = pc_ctr + 16'd1;
	endtask

	always @(negedge clk) begin : compare_outputs
		exp_t  e;
		string n;
		neg_cnt = neg_cnt + 1;
		if (exp_q.size() > 0 && exp_q[0].due == neg_cnt) begin
			e = exp_q.pop_front();
			n = name_q.pop_front();
			check(n, "reg_write_out", e.rw, reg_write_out);
			check(n, "mem_read_out", e.mr, mem_read_out);
			check(n, "mem_write_out", e.mw, mem_write_out);
			check(n, "pc_out", e.pcv, pc_out);
			check(n, "mem_act", e.act, mem_act);
			if (e.rw || e.mr || e.mw)
				check(n, "alu_result", e.result, alu_result);
			if (e.rw)
				check(n, "reg_addr_out", e.ra, reg_addr_out);
			if (e.mw)
				check(n, "mem_write_value", e.wval, mem_write_value);
		end
	end

	// ADDIU r, 0 shows each general register on alu_result
	task automatic read_back();
		for (int r = 0; r < 8; r++)
			step("ADDIU rd", imm8_word(OPC_ADDIU, 3'(r), 8'd0), 1'b0, 1'b0);
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_chk0 = chk_cnt;
		test_err0 = err_cnt;
	endtask

	task automatic end_test();
		int waited;
		step("NOP", NOP_WORD, 1'b0, 1'b0);
		waited = 0;
		while (exp_q.size() != 0 && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			err_cnt++;
			$display("Timeout: outputs of %s were never sampled", cur_test);
			exp_q.delete();
			name_q.delete();
		end else begin
			$display("%s done: %0d checks, %0d mismatches", cur_test,
				chk_cnt - test_chk0, err_cnt - test_err0);
		end
	endtask

	initial begin
		int         op;
		logic [2:0] a;
		logic [2:0] b;
		logic [2:0] c;
		logic [7:0] imm;
		void'($urandom(32'h3b81));
		arst_n = 1'b0;
		instr  = NOP_WORD;
		pc     = '0;
		hold   = 1'b0;
		flush  = 1'b0;
		for (int r = 0; r < NUM_REGS; r++)
			model_rf[r] = '0;
		cur       = '0;
		act_model = '0;
		pc_ctr    = 16'h0100;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		begin_test("alu_seq");
		read_back(); // All zero after reset
		for (int r = 0; r < 8; r++)
			step("LI", imm8_word(OPC_LI, 3'(r), any_byte()), 1'b0, 1'b0);
		for (int i = 0; i < 4; i++)
			step("ADDU chain", rr_word(OPC_RR, 3'd1, 3'd1, {3'd1, FN_ADDU}), 1'b0, 1'b0);
		for (int i = 0; i < 40; i++) begin
			op = $urandom % 5;
			a  = any_reg();
			b  = any_reg();
			c  = any_reg();
			case (op)
				0: step("ADDU", rr_word(OPC_RR, a, b, {c, FN_ADDU}), 1'b0, 1'b0);
				1: step("SUBU", rr_word(OPC_RR, a, b, {c, FN_SUBU}), 1'b0, 1'b0);
				2: step("AND", rr_word(OPC_ALU, a, b, FN_AND), 1'b0, 1'b0);
				3: step("OR", rr_word(OPC_ALU, a, b, FN_OR), 1'b0, 1'b0);
				default: step("MOVE", rr_word(OPC_MOVE, a, b, 5'd0), 1'b0, 1'b0);
			endcase
		end
		read_back();
		end_test();

		begin_test("imm_forms");
		step("LI", imm8_word(OPC_LI, 3'd6, 8'h80), 1'b0, 1'b0);
		step("MTSP", rr_word(OPC_SPEC, FN_MTSP, 3'd6, 5'd0), 1'b0, 1'b0); // SP base
		step("ADDIU neg", imm8_word(OPC_ADDIU, 3'd0, 8'h80), 1'b0, 1'b0);
		step("ADDIU3 neg", rr_word(OPC_ADDIU3, 3'd2, 3'd3, 5'h08), 1'b0, 1'b0);
		step("LW neg", rr_word(OPC_LW, 3'd4, 3'd5, 5'h10), 1'b0, 1'b0);
		step("SW pos", rr_word(OPC_SW, 3'd4, 3'd5, 5'h0f), 1'b0, 1'b0);
		for (int i = 0; i < 30; i++) begin
			op  = $urandom % 5;
			a   = any_reg();
			b   = any_reg();
			imm = any_byte();
			case (op)
				0: step("ADDIU", imm8_word(OPC_ADDIU, a, imm), 1'b0, 1'b0);
				1: step("ADDIU3", rr_word(OPC_ADDIU3, a, b, {1'b0, imm[3:0]}), 1'b0, 1'b0);
				2: step("ADDSP", imm8_word(OPC_SPEC, FN_ADDSP, imm), 1'b0, 1'b0);
				3: step("LW", rr_word(OPC_LW, a, b, imm[4:0]), 1'b0, 1'b0);
				default: step("SW", rr_word(OPC_SW, a, b, imm[4:0]), 1'b0, 1'b0);
			endcase
		end
		end_test();

		begin_test("shift_special");
		step("LI", imm8_word(OPC_LI, 3'd1, 8'h9c), 1'b0, 1'b0);
		step("SLL 8", rr_word(OPC_SHIFT, 3'd1, 3'd1, {3'd0, FN_SLL}), 1'b0, 1'b0);
		step("SRA 8", rr_word(OPC_SHIFT, 3'd2, 3'd1, {3'd0, FN_SRA}), 1'b0, 1'b0);
		step("SRL 8", rr_word(OPC_SHIFT, 3'd3, 3'd1, {3'd0, FN_SRL}), 1'b0, 1'b0);
		for (int i = 0; i < 16; i++) begin
			op = $urandom % 3;
			a  = any_reg();
			b  = any_reg();
			c  = any_reg(); // Shift amount
			case (op)
				0: step("SLL", rr_word(OPC_SHIFT, a, b, {c, FN_SLL}), 1'b0, 1'b0);
				1: step("SRA", rr_word(OPC_SHIFT, a, b, {c, FN_SRA}), 1'b0, 1'b0);
				default: step("SRL", rr_word(OPC_SHIFT, a, b, {c, FN_SRL}), 1'b0, 1'b0);
			endcase
		end
		step("LI", imm8_word(OPC_LI, 3'd4, 8'd1), 1'b0, 1'b0);
		step("LI", imm8_word(OPC_LI, 3'd5, 8'd2), 1'b0, 1'b0);
		step("CMP eq", rr_word(OPC_ALU, 3'd2, 3'd2, FN_CMP), 1'b0, 1'b0);
		step("CMP ne", rr_word(OPC_ALU, 3'd4, 3'd5, FN_CMP), 1'b0, 1'b0);
		step("CMP", rr_word(OPC_ALU, any_reg(), any_reg(), FN_CMP), 1'b0, 1'b0);
		step("MFPC", imm8_word(OPC_ALU, 3'd7, FN_MFPC), 1'b0, 1'b0);
		step("MFPC", imm8_word(OPC_ALU, 3'd6, FN_MFPC), 1'b0, 1'b0);
		step("MTSP", rr_word(OPC_SPEC, FN_MTSP, 3'd1, 5'd0), 1'b0, 1'b0);
		step("ADDSP 0", imm8_word(OPC_SPEC, FN_ADDSP, 8'd0), 1'b0, 1'b0);
		step("MTIH", imm8_word(OPC_IH, 3'd2, FN_MTIH), 1'b0, 1'b0);
		step("MFIH", imm8_word(OPC_IH, 3'd0, FN_MFIH), 1'b0, 1'b0);
		read_back();
		end_test();

		begin_test("hold");
		step("LI", imm8_word(OPC_LI, 3'd3, 8'h55), 1'b0, 1'b0);
		step("ADDIU", imm8_word(OPC_ADDIU, 3'd3, 8'h01), 1'b0, 1'b0);
		for (int i = 0; i < 4; i++)
			step("held", imm8_word(OPC_ADDIU, 3'd4, 8'h10), 1'b1, 1'b0);
		step("hold over flush", imm8_word(OPC_ADDIU, 3'd4, 8'h10), 1'b1, 1'b1);
		step("ADDIU", imm8_word(OPC_ADDIU, 3'd4, 8'h10), 1'b0, 1'b0);
		step("LW", rr_word(OPC_LW, 3'd3, 3'd5, 5'h02), 1'b0, 1'b0);
		for (int i = 0; i < 5; i++)
			step("held", rr_word(OPC_SW, 3'd4, 3'd3, 5'h1f), 1'b1, 1'b0);
		step("SW", rr_word(OPC_SW, 3'd4, 3'd3, 5'h1f), 1'b0, 1'b0);
		read_back();
		end_test();

		begin_test("flush_mem");
		step("LI", imm8_word(OPC_LI, 3'd2, any_byte()), 1'b0, 1'b0);
		step("flushed SW", rr_word(OPC_SW, 3'd1, 3'd2, 5'd3), 1'b0, 1'b1);
		step("flushed ADDIU", imm8_word(OPC_ADDIU, 3'd2, 8'h7f), 1'b0, 1'b1);
		step("LW", rr_word(OPC_LW, 3'd1, 3'd2, 5'd1), 1'b0, 1'b0);
		step("flushed SW", rr_word(OPC_SW, 3'd1, 3'd2, 5'd3), 1'b0, 1'b1);
		for (int i = 0; i < 24; i++) begin
			op  = $urandom % 4;
			a   = any_reg();
			b   = any_reg();
			imm = any_byte();
			c   = any_reg(); // Picks hold and flush
			case (op)
				0: step("LW", rr_word(OPC_LW, a, b, imm[4:0]), c == 3'd0, c == 3'd1);
				1: step("SW", rr_word(OPC_SW, a, b, imm[4:0]), c == 3'd0, c == 3'd1);
				2: step("LW_SP", imm8_word(OPC_LW_SP, a, imm), c == 3'd0, c == 3'd1);
				default: step("SW_SP", imm8_word(OPC_SW_SP, a, imm), c == 3'd0, c == 3'd1);
			endcase
		end
		read_back();
		end_test();

		$display("All tests: %0d checks, %0d mismatches", chk_cnt, err_cnt);
		if (err_cnt == 0 && chk_cnt > 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
